// File: rtl/id_pkg.sv
package id_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int ALU_OPS = 12;

    // bit positions in the one-hot alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // rt field of REGIMM
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } inst_word_u;

endpackage

// File: rtl/id_regfile.sv
module id_regfile import id_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2
);

    logic [XLEN-1:0] regs [2**REG_AW];

    // r0 is hardwired, never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a write with an unknown address would corrupt the whole array
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("regfile write with unknown address");

endmodule

// File: rtl/ds_inst_latch.sv
module ds_inst_latch import id_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            fs_to_ds_valid,
    input  logic [XLEN-1:0] fs_inst,
    input  logic [XLEN-1:0] fs_pc,
    input  logic            ready_go,
    input  logic            es_allowin,
    output logic            ds_valid,
    output logic            ds_allowin,
    output logic            ds_to_es_valid,
    output inst_word_u      ds_inst,
    output logic [XLEN-1:0] ds_pc
);

    // empty, or the held instruction leaves this cycle
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    // held word must not change while execute refuses it
    a_hold: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin |=> ds_valid && $stable(ds_inst) && $stable(ds_pc)
    ) else $error("held instruction changed under back-pressure");

endmodule

// File: rtl/inst_decoder.sv
module inst_decoder import id_pkg::*; (
    input  inst_word_u         ds_inst,
    output logic [ALU_OPS-1:0] alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_is_uimm,
    output logic               src2_is_8,
    output logic               res_from_mem,
    output logic               gr_we,
    output logic               mem_we,
    output logic [REG_AW-1:0]  dest,
    output logic [15:0]        imm,
    output logic               is_beq,
    output logic               is_bne,
    output logic               is_bgez,
    output logic               is_bgtz,
    output logic               is_blez,
    output logic               is_bltz,
    output logic               is_j,
    output logic               is_jal,
    output logic               is_jr
);

    logic special;
    logic sa_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic dst_is_rt;

    assign special = ds_inst.r.op == OP_SPECIAL;
    assign sa_zero = ds_inst.r.sa == '0;

    // register type, three-operand
    assign inst_addu = special && ds_inst.r.func == FN_ADDU && sa_zero;
    assign inst_subu = special && ds_inst.r.func == FN_SUBU && sa_zero;
    assign inst_slt  = special && ds_inst.r.func == FN_SLT  && sa_zero;
    assign inst_sltu = special && ds_inst.r.func == FN_SLTU && sa_zero;
    assign inst_and  = special && ds_inst.r.func == FN_AND  && sa_zero;
    assign inst_or   = special && ds_inst.r.func == FN_OR   && sa_zero;
    assign inst_xor  = special && ds_inst.r.func == FN_XOR  && sa_zero;
    assign inst_nor  = special && ds_inst.r.func == FN_NOR  && sa_zero;

    // shifts by sa, rs must be zero
    assign inst_sll = special && ds_inst.r.func == FN_SLL && ds_inst.r.rs == '0;
    assign inst_srl = special && ds_inst.r.func == FN_SRL && ds_inst.r.rs == '0;
    assign inst_sra = special && ds_inst.r.func == FN_SRA && ds_inst.r.rs == '0;

    assign is_jr = special && ds_inst.r.func == FN_JR && ds_inst.r.rt == '0
                   && ds_inst.r.rd == '0 && sa_zero;

    assign inst_addiu = ds_inst.i.op == OP_ADDIU;
    assign inst_slti  = ds_inst.i.op == OP_SLTI;
    assign inst_sltiu = ds_inst.i.op == OP_SLTIU;
    assign inst_andi  = ds_inst.i.op == OP_ANDI;
    assign inst_ori   = ds_inst.i.op == OP_ORI;
    assign inst_xori  = ds_inst.i.op == OP_XORI;
    assign inst_lui   = ds_inst.i.op == OP_LUI && ds_inst.i.rs == '0;
    assign inst_lw    = ds_inst.i.op == OP_LW;
    assign inst_sw    = ds_inst.i.op == OP_SW;

    assign is_beq  = ds_inst.i.op == OP_BEQ;
    assign is_bne  = ds_inst.i.op == OP_BNE;
    assign is_bgez = ds_inst.i.op == OP_REGIMM && ds_inst.i.rt == RT_BGEZ;
    assign is_bltz = ds_inst.i.op == OP_REGIMM && ds_inst.i.rt == RT_BLTZ;
    assign is_bgtz = ds_inst.i.op == OP_BGTZ && ds_inst.i.rt == '0;
    assign is_blez = ds_inst.i.op == OP_BLEZ && ds_inst.i.rt == '0;
    assign is_j    = ds_inst.i.op == OP_J;
    assign is_jal  = ds_inst.i.op == OP_JAL;

    // jal computes pc + 8 through the adder
    assign alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | is_jal;
    assign alu_op[ALU_SUB]  = inst_subu;
    assign alu_op[ALU_SLT]  = inst_slt  | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[ALU_AND]  = inst_and  | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or   | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor  | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll;
    assign alu_op[ALU_SRL]  = inst_srl;
    assign alu_op[ALU_SRA]  = inst_sra;
    assign alu_op[ALU_LUI]  = inst_lui;

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = is_jal;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_uimm = inst_andi | inst_ori | inst_xori;
    assign src2_is_8    = is_jal;

    assign res_from_mem = inst_lw;
    assign mem_we       = inst_sw;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                       | inst_xori | inst_lui | inst_lw;

    assign gr_we = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra
                   | dst_is_rt | is_jal;

    // no destination for anything that does not write
    assign dest = !gr_we    ? '0 :
                  is_jal    ? REG_AW'(31) :
                  dst_is_rt ? ds_inst.i.rt :
                              ds_inst.r.rd;

    assign imm = ds_inst.i.imm16;

endmodule

// File: rtl/operand_bypass.sv
module operand_bypass import id_pkg::*; (
    input  logic              clk,
    input  inst_word_u        ds_inst,
    input  logic              es_fwd_valid,
    input  logic              es_blk_valid,
    input  logic [REG_AW-1:0] es_rf_dest,
    input  logic [XLEN-1:0]   es_rf_data,
    input  logic              ms_fwd_valid,
    input  logic [REG_AW-1:0] ms_rf_dest,
    input  logic [XLEN-1:0]   ms_rf_data,
    input  logic              ws_we,
    input  logic [REG_AW-1:0] ws_waddr,
    input  logic [XLEN-1:0]   ws_wdata,
    output logic [XLEN-1:0]   rs_value,
    output logic [XLEN-1:0]   rt_value,
    output logic              ready_go
);

    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic              load_use;

    assign rs = ds_inst.r.rs;
    assign rt = ds_inst.r.rt;

    id_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .we     (ws_we),
        .waddr  (ws_waddr),
        .wdata  (ws_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // youngest producer wins, r0 is never forwarded
    always_comb begin
        if (rs != '0 && es_fwd_valid && es_rf_dest == rs) begin
            rs_value = es_rf_data;
        end else if (rs != '0 && ms_fwd_valid && ms_rf_dest == rs) begin
            rs_value = ms_rf_data;
        end else if (rs != '0 && ws_we && ws_waddr == rs) begin
            rs_value = ws_wdata;
        end else begin
            rs_value = rf_rdata1;
        end
    end

    always_comb begin
        if (rt != '0 && es_fwd_valid && es_rf_dest == rt) begin
            rt_value = es_rf_data;
        end else if (rt != '0 && ms_fwd_valid && ms_rf_dest == rt) begin
            rt_value = ms_rf_data;
        end else if (rt != '0 && ws_we && ws_waddr == rt) begin
            rt_value = ws_wdata;
        end else begin
            rt_value = rf_rdata2;
        end
    end

    // load data not ready until memory stage
    assign load_use = es_blk_valid && es_rf_dest != '0
                      && (es_rf_dest == rs || es_rf_dest == rt);
    assign ready_go = !load_use;

endmodule

// File: rtl/branch_resolver.sv
module branch_resolver import id_pkg::*; (
    input  logic            ds_valid,
    input  logic            ready_go,
    input  logic            es_allowin,
    input  inst_word_u      ds_inst,
    input  logic [XLEN-1:0] ds_pc,
    input  logic [XLEN-1:0] rs_value,
    input  logic [XLEN-1:0] rt_value,
    input  logic            is_beq,
    input  logic            is_bne,
    input  logic            is_bgez,
    input  logic            is_bgtz,
    input  logic            is_blez,
    input  logic            is_bltz,
    input  logic            is_j,
    input  logic            is_jal,
    input  logic            is_jr,
    output logic            br_taken,
    output logic            br_stall,
    output logic [XLEN-1:0] br_target
);

    logic            is_cond;
    logic            is_branch;
    logic            rs_eq_rt;
    logic            rs_neg;
    logic            rs_zero;
    logic            cond_taken;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] offset;

    assign is_cond   = is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz;
    assign is_branch = is_cond | is_j | is_jal | is_jr;

    assign rs_eq_rt = rs_value == rt_value;
    assign rs_neg   = rs_value[XLEN-1];
    assign rs_zero  = rs_value == '0;

    assign cond_taken = (is_beq  &&  rs_eq_rt)
                     || (is_bne  && !rs_eq_rt)
                     || (is_bgez && !rs_neg)
                     || (is_bgtz && !rs_neg && !rs_zero)
                     || (is_blez && (rs_neg || rs_zero))
                     || (is_bltz && rs_neg);

    assign br_taken = ds_valid && (cond_taken || is_j || is_jal || is_jr);

    // fetch waits until the branch can actually leave
    assign br_stall = ds_valid && is_branch && !(ready_go && es_allowin);

    assign pc_plus4 = ds_pc + XLEN'(4);
    assign offset   = {{(XLEN-18){ds_inst.i.imm16[15]}}, ds_inst.i.imm16, 2'b00};

    assign br_target = is_cond ? pc_plus4 + offset :
                       is_jr   ? rs_value :
                                 {pc_plus4[XLEN-1:28], ds_inst[25:0], 2'b00};

endmodule

// File: rtl/id_stage.sv
module id_stage import id_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    // fetch handshake
    input  logic               fs_to_ds_valid,
    input  logic [XLEN-1:0]    fs_inst,
    input  logic [XLEN-1:0]    fs_pc,
    output logic               ds_allowin,
    // execute handshake
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output logic [ALU_OPS-1:0] alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_is_uimm,
    output logic               src2_is_8,
    output logic               res_from_mem,
    output logic               gr_we,
    output logic               mem_we,
    output logic [REG_AW-1:0]  dest,
    output logic [15:0]        imm,
    output logic [XLEN-1:0]    pc,
    output logic [XLEN-1:0]    rs_value,
    output logic [XLEN-1:0]    rt_value,
    // bypass sources
    input  logic               es_fwd_valid,
    input  logic               es_blk_valid,
    input  logic [REG_AW-1:0]  es_rf_dest,
    input  logic [XLEN-1:0]    es_rf_data,
    input  logic               ms_fwd_valid,
    input  logic [REG_AW-1:0]  ms_rf_dest,
    input  logic [XLEN-1:0]    ms_rf_data,
    input  logic               ws_we,
    input  logic [REG_AW-1:0]  ws_waddr,
    input  logic [XLEN-1:0]    ws_wdata,
    // to fetch
    output logic               br_taken,
    output logic [XLEN-1:0]    br_target,
    output logic               br_stall
);

    logic       ds_valid;
    logic       ready_go;
    inst_word_u ds_inst;
    logic       is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
    logic       is_j, is_jal, is_jr;

    ds_inst_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ds_valid       (ds_valid),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_inst        (ds_inst),
        .ds_pc          (pc)
    );

    inst_decoder u_decoder (
        .ds_inst      (ds_inst),
        .alu_op       (alu_op),
        .src1_is_sa   (src1_is_sa),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .src2_is_uimm (src2_is_uimm),
        .src2_is_8    (src2_is_8),
        .res_from_mem (res_from_mem),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .dest         (dest),
        .imm          (imm),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_bgez      (is_bgez),
        .is_bgtz      (is_bgtz),
        .is_blez      (is_blez),
        .is_bltz      (is_bltz),
        .is_j         (is_j),
        .is_jal       (is_jal),
        .is_jr        (is_jr)
    );

    operand_bypass u_bypass (
        .clk          (clk),
        .ds_inst      (ds_inst),
        .es_fwd_valid (es_fwd_valid),
        .es_blk_valid (es_blk_valid),
        .es_rf_dest   (es_rf_dest),
        .es_rf_data   (es_rf_data),
        .ms_fwd_valid (ms_fwd_valid),
        .ms_rf_dest   (ms_rf_dest),
        .ms_rf_data   (ms_rf_data),
        .ws_we        (ws_we),
        .ws_waddr     (ws_waddr),
        .ws_wdata     (ws_wdata),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .ready_go     (ready_go)
    );

    branch_resolver u_branch (
        .ds_valid   (ds_valid),
        .ready_go   (ready_go),
        .es_allowin (es_allowin),
        .ds_inst    (ds_inst),
        .ds_pc      (pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .is_beq     (is_beq),
        .is_bne     (is_bne),
        .is_bgez    (is_bgez),
        .is_bgtz    (is_bgtz),
        .is_blez    (is_blez),
        .is_bltz    (is_bltz),
        .is_j       (is_j),
        .is_jal     (is_jal),
        .is_jr      (is_jr),
        .br_taken   (br_taken),
        .br_stall   (br_stall),
        .br_target  (br_target)
    );

endmodule

// File: tb/tb_id_stage.sv
module tb_id_stage import id_pkg::*; ();

    localparam int MAX_CYCLES = 2000;
    localparam int SETTLE     = 10;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               fs_to_ds_valid = 1'b0;
    logic [XLEN-1:0]    fs_inst = '0;
    logic [XLEN-1:0]    fs_pc = '0;
    logic               es_allowin = 1'b1;
    logic               es_fwd_valid = 1'b0;
    logic               es_blk_valid = 1'b0;
    logic [REG_AW-1:0]  es_rf_dest = '0;
    logic [XLEN-1:0]    es_rf_data = '0;
    logic               ms_fwd_valid = 1'b0;
    logic [REG_AW-1:0]  ms_rf_dest = '0;
    logic [XLEN-1:0]    ms_rf_data = '0;
    logic               ws_we = 1'b0;
    logic [REG_AW-1:0]  ws_waddr = '0;
    logic [XLEN-1:0]    ws_wdata = '0;
    logic               ds_allowin, ds_to_es_valid, br_taken, br_stall;
    logic               src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8;
    logic               res_from_mem, gr_we, mem_we;
    logic [ALU_OPS-1:0] alu_op;
    logic [REG_AW-1:0]  dest;
    logic [15:0]        imm;
    logic [XLEN-1:0]    pc, rs_value, rt_value, br_target;
    integer             seed = 32'ha30a_d2aa;
    int                 cycles = 0;
    string              test_name = "reset";

    id_stage u_dut (.*);

    always #50 clk = ~clk;

    // far beyond the summed length of all tests
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no progress after %0d cycles in %s", MAX_CYCLES, test_name);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string what, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h actual %h",
                     test_name, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [XLEN-1:0] r_format(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] sa,
                                                 input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] off);
        return {op, rs, rt, off};
    endfunction

    // offer one word and return on the falling edge after the transfer
    task automatic issue(input logic [XLEN-1:0] word, input logic [XLEN-1:0] at_pc);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst        = word;
        fs_pc          = at_pc;
        #SETTLE;
        while (!ds_allowin) begin
            @(negedge clk);
            #SETTLE;
        end
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic decode_check(input string what, input logic [XLEN-1:0] word,
                                input logic [ALU_OPS-1:0] exp_alu, input logic [4:0] exp_sel,
                                input logic [REG_AW-1:0] exp_dest, input logic [2:0] exp_wr);
        test_name = what;
        issue(word, 32'h0040_0000);
        #SETTLE;
        check("ds_to_es_valid", 1'b1, ds_to_es_valid);
        check("alu_op", exp_alu, alu_op);
        check("selects", exp_sel,
              {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8});
        check("dest", exp_dest, dest);
        check("write enables", exp_wr, {gr_we, res_from_mem, mem_we});
        // immediate field is the low half of the word
        check("imm", word[15:0], imm);
    endtask

    task automatic decode_tests();
        decode_check("addu", r_format(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU),
                     ALU_OPS'(1) << ALU_ADD, 5'b00000, 5'd3, 3'b100);
        decode_check("ori", i_format(OP_ORI, 5'd4, 5'd5, 16'h00ff),
                     ALU_OPS'(1) << ALU_OR, 5'b00010, 5'd5, 3'b100);
        decode_check("lui", i_format(OP_LUI, 5'd0, 5'd6, 16'h1234),
                     ALU_OPS'(1) << ALU_LUI, 5'b00100, 5'd6, 3'b100);
        decode_check("sll", r_format(5'd0, 5'd8, 5'd7, 5'd4, FN_SLL),
                     ALU_OPS'(1) << ALU_SLL, 5'b10000, 5'd7, 3'b100);
        decode_check("lw", i_format(OP_LW, 5'd10, 5'd9, 16'h0008),
                     ALU_OPS'(1) << ALU_ADD, 5'b00100, 5'd9, 3'b110);
        // opcode 0x3f is outside the subset
        decode_check("unknown", 32'hfc00_0000, '0, 5'b00000, 5'd0, 3'b000);
    endtask

    task automatic regfile_reads();
        logic [XLEN-1:0] vals [3];
        test_name = "regfile_reads";
        @(negedge clk);
        // index 0 targets r0, which must drop the write
        for (int k = 0; k < 3; k++) begin
            vals[k]  = $random(seed);
            ws_we    = 1'b1;
            ws_waddr = (k == 0) ? 5'd0 : REG_AW'(10 + k);
            ws_wdata = vals[k];
            @(negedge clk);
        end
        ws_we = 1'b0;
        issue(r_format(5'd11, 5'd12, 5'd13, 5'd0, FN_ADDU), 32'h0040_0100);
        #SETTLE;
        check("rs_value", vals[1], rs_value);
        check("rt_value", vals[2], rt_value);
        issue(r_format(5'd0, 5'd11, 5'd13, 5'd0, FN_ADDU), 32'h0040_0104);
        #SETTLE;
        check("r0 read", '0, rs_value);
        check("rt_value", vals[1], rt_value);
    endtask

    task automatic bypass_priority();
        test_name = "bypass_priority";
        issue(r_format(5'd14, 5'd0, 5'd15, 5'd0, FN_ADDU), 32'h0040_0200);
        es_fwd_valid = 1'b1;
        es_rf_dest   = 5'd14;
        es_rf_data   = 32'h1111_1111;
        ms_fwd_valid = 1'b1;
        ms_rf_dest   = 5'd14;
        ms_rf_data   = 32'h2222_2222;
        ws_we        = 1'b1;
        ws_waddr     = 5'd14;
        ws_wdata     = 32'h3333_3333;
        #SETTLE;
        check("execute first", 32'h1111_1111, rs_value);
        // each edge also writes r14, so writeback offers a new value every cycle
        @(negedge clk);
        es_fwd_valid = 1'b0;
        ws_wdata     = 32'h4444_4444;
        #SETTLE;
        check("memory second", 32'h2222_2222, rs_value);
        @(negedge clk);
        ms_fwd_valid = 1'b0;
        ws_wdata     = 32'h5555_5555;
        #SETTLE;
        check("writeback third", 32'h5555_5555, rs_value);
        @(negedge clk);
        ws_we = 1'b0;
        #SETTLE;
        check("register file last", 32'h5555_5555, rs_value);
        issue(r_format(5'd0, 5'd0, 5'd15, 5'd0, FN_ADDU), 32'h0040_0204);
        es_fwd_valid = 1'b1;
        es_rf_dest   = 5'd0;
        ms_fwd_valid = 1'b1;
        ms_rf_dest   = 5'd0;
        #SETTLE;
        check("r0 not forwarded rs", '0, rs_value);
        check("r0 not forwarded rt", '0, rt_value);
        @(negedge clk);
        es_fwd_valid = 1'b0;
        ms_fwd_valid = 1'b0;
    endtask

    task automatic load_use_stall();
        test_name = "load_use_stall";
        issue(i_format(OP_BEQ, 5'd16, 5'd17, 16'h0004), 32'h0040_0300);
        es_blk_valid = 1'b1;
        es_rf_dest   = 5'd17;
        repeat (2) begin
            #SETTLE;
            check("ds_to_es_valid", 1'b0, ds_to_es_valid);
            check("ds_allowin", 1'b0, ds_allowin);
            check("br_stall", 1'b1, br_stall);
            @(negedge clk);
        end
        es_blk_valid = 1'b0;
        #SETTLE;
        check("ds_to_es_valid after release", 1'b1, ds_to_es_valid);
        check("br_stall after release", 1'b0, br_stall);
        check("pc held", 32'h0040_0300, pc);
    endtask

    task automatic branch_check(input string what, input logic [XLEN-1:0] word,
                                input logic [XLEN-1:0] at_pc, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b, input logic exp_taken,
                                input logic [XLEN-1:0] exp_target);
        test_name = what;
        issue(word, at_pc);
        // r18 and r19 arrive through the bypass
        es_fwd_valid = 1'b1;
        es_rf_dest   = 5'd18;
        es_rf_data   = a;
        ms_fwd_valid = 1'b1;
        ms_rf_dest   = 5'd19;
        ms_rf_data   = b;
        #SETTLE;
        check("br_taken", exp_taken, br_taken);
        check("br_target", exp_target, br_target);
        check("br_stall", 1'b0, br_stall);
    endtask

    task automatic branch_outcomes();
        logic [XLEN-1:0] bpc, jpc, tgt, neg;
        logic [XLEN-1:0] beq_w, bne_w, bgtz_w, bltz_w;
        bpc    = 32'h0040_1000;
        // pc + 4 lands in the 0x2 region
        jpc    = 32'h1fff_fffc;
        // offset 0xfff0 is -64 bytes from pc + 4
        tgt    = 32'h0040_0fc4;
        neg    = 32'h8000_0004;
        beq_w  = i_format(OP_BEQ, 5'd18, 5'd19, 16'hfff0);
        bne_w  = i_format(OP_BNE, 5'd18, 5'd19, 16'hfff0);
        bgtz_w = i_format(OP_BGTZ, 5'd18, 5'd0, 16'hfff0);
        bltz_w = i_format(OP_REGIMM, 5'd18, RT_BLTZ, 16'hfff0);
        branch_check("beq equal", beq_w, bpc, 5, 5, 1'b1, tgt);
        branch_check("beq unequal", beq_w, bpc, 5, 6, 1'b0, tgt);
        branch_check("bne equal", bne_w, bpc, 5, 5, 1'b0, tgt);
        branch_check("bne unequal", bne_w, bpc, 5, 6, 1'b1, tgt);
        branch_check("bgtz positive", bgtz_w, bpc, 7, 0, 1'b1, tgt);
        branch_check("bgtz zero", bgtz_w, bpc, 0, 0, 1'b0, tgt);
        branch_check("bgtz negative", bgtz_w, bpc, neg, 0, 1'b0, tgt);
        branch_check("bltz positive", bltz_w, bpc, 7, 0, 1'b0, tgt);
        branch_check("bltz zero", bltz_w, bpc, 0, 0, 1'b0, tgt);
        branch_check("bltz negative", bltz_w, bpc, neg, 0, 1'b1, tgt);
        branch_check("j", {OP_J, 26'h0123456}, jpc, 0, 0, 1'b1, 32'h2048_d158);
        branch_check("jal", {OP_JAL, 26'h3abcdef}, jpc, 0, 0, 1'b1, 32'h2eaf_37bc);
        branch_check("jr", r_format(5'd18, 5'd0, 5'd0, 5'd0, FN_JR), bpc,
                     32'h0040_2468, 0, 1'b1, 32'h0040_2468);
        @(negedge clk);
        es_fwd_valid = 1'b0;
        ms_fwd_valid = 1'b0;
    endtask

    task automatic back_pressure();
        test_name = "back_pressure";
        @(negedge clk);
        es_allowin = 1'b0;
        issue(i_format(OP_ORI, 5'd0, 5'd20, 16'h0001), 32'h0040_0400);
        fs_to_ds_valid = 1'b1;
        fs_inst        = i_format(OP_XORI, 5'd0, 5'd21, 16'h0002);
        fs_pc          = 32'h0040_0404;
        repeat (2) begin
            #SETTLE;
            check("ds_allowin", 1'b0, ds_allowin);
            check("pc held", 32'h0040_0400, pc);
            check("dest held", 5'd20, dest);
            @(negedge clk);
        end
        es_allowin = 1'b1;
        #SETTLE;
        check("ds_allowin released", 1'b1, ds_allowin);
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        #SETTLE;
        check("second pc", 32'h0040_0404, pc);
        check("second dest", 5'd21, dest);
        check("ds_to_es_valid", 1'b1, ds_to_es_valid);
    endtask

    initial begin
        repeat (3) @(negedge clk);
        reset = 1'b0;
        #SETTLE;
        check("ds_to_es_valid", 1'b0, ds_to_es_valid);
        check("br_taken", 1'b0, br_taken);
        check("br_stall", 1'b0, br_stall);
        check("ds_allowin", 1'b1, ds_allowin);
        decode_tests();
        regfile_reads();
        bypass_priority();
        load_use_stall();
        branch_outcomes();
        back_pressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: build.f
rtl/id_pkg.sv
rtl/id_regfile.sv
rtl/ds_inst_latch.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/branch_resolver.sv
rtl/id_stage.sv
tb/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - rtl/id_pkg.sv
  - rtl/id_regfile.sv
  - rtl/ds_inst_latch.sv
  - rtl/inst_decoder.sv
  - rtl/operand_bypass.sv
  - rtl/branch_resolver.sv
  - rtl/id_stage.sv
  - target: test
    files:
      - tb/tb_id_stage.sv
